// ==== Bender.yml ====
package:
  name: fdtd_mem_ctrl

dependencies: {}

sources:
  - files:
      - fdtd_cfg_pkg.sv
      - fdtd_mem_pkg.sv
      - fdtd_addr_gen.sv
      - fdtd_mem_port.sv
      - fdtd_seq_fsm.sv
      - fdtd_status.sv
      - fdtd_mem_ctrl.sv
  - target: simulation
    files:
      - tb_word_mem.sv
      - tb_fdtd_mem_ctrl.sv

// ==== fdtd_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_addr_gen
    import fdtd_cfg_pkg::*, fdtd_mem_pkg::*;
(
    input  wire               ACLK,
    input  wire               ARESETn,

    input  wire seq_ctrl_t    ctrl_i,
    input  wire word_addr_t   hy_base_i,
    input  wire word_addr_t   ez_base_i,
    input  wire word_count_t  size_i,

    output word_addr_t        rd_addr_o,
    output word_addr_t        wr_addr_o,
    output word_count_t       remaining_o
);

    word_addr_t  rd_hy_q;
    word_addr_t  rd_ez_q;
    word_addr_t  wr_hy_q;
    word_addr_t  wr_ez_q;
    word_count_t remaining_q;

    ////////////////////
    // read pointers
    ////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            rd_hy_q <= '0;
            rd_ez_q <= '0;
        end
        else if (ctrl_i.load)
        begin
            rd_hy_q <= hy_base_i;
            rd_ez_q <= ez_base_i;
        end
        else if (ctrl_i.rd_issue)
        begin
            if (ctrl_i.rd_field == FIELD_HY)
                rd_hy_q <= rd_hy_q + 1'b1;
            else
                rd_ez_q <= rd_ez_q + 1'b1;
        end
    end

    ////////////////////
    // write pointers
    ////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            wr_hy_q <= '0;
            wr_ez_q <= '0;
        end
        else if (ctrl_i.load)
        begin
            wr_hy_q <= hy_base_i;
            wr_ez_q <= ez_base_i;
        end
        else if (ctrl_i.wr_issue)
        begin
            if (ctrl_i.wr_field == FIELD_HY)
                wr_hy_q <= wr_hy_q + 1'b1;
            else
                wr_ez_q <= wr_ez_q + 1'b1;
        end
    end

    // drops by one chunk once its write-back is done
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            remaining_q <= '0;
        else if (ctrl_i.load)
            remaining_q <= size_i;
        else if (ctrl_i.chunk_adv)
            remaining_q <= remaining_q - word_count_t'(chunk_len_f(remaining_q));
    end

    assign rd_addr_o   = (ctrl_i.rd_field == FIELD_HY) ? rd_hy_q : rd_ez_q;
    assign wr_addr_o   = (ctrl_i.wr_field == FIELD_HY) ? wr_hy_q : wr_ez_q;
    assign remaining_o = remaining_q;

endmodule

`default_nettype wire

// ==== fdtd_cases.txt ====
// field (0 hy, 1 ez)  size  hy base  ez base  irq enable  read latency bound
// one run per line, all values hex, sizes and bases in words
0 0010 0100 0200 1 1
1 0010 0300 0400 0 8
0 0025 1000 2000 1 4
1 0025 1100 2100 1 8
0 0005 3000 3010 0 2
1 0005 3020 3030 1 1
0 0030 4000 5000 1 3
1 0011 6000 7000 0 5
1 0020 8000 9000 1 6
0 0003 a000 b000 1 8
0 0001 c000 c100 0 7
1 0040 d000 e000 1 2

// ==== fdtd_cfg_pkg.sv ====
`default_nettype none

package fdtd_cfg_pkg;

    // word-addressed memory, one sample per word
    typedef logic [15:0] word_addr_t;
    typedef logic [31:0] field_word_t;

    // words still to update in the current pass
    typedef logic [15:0] word_count_t;

    // words within one chunk, must hold BUF_WORDS itself
    typedef logic [4:0] chunk_count_t;

    // line buffer depth in words
    localparam word_count_t BUF_WORDS = 16;

    typedef enum logic {
        FIELD_HY = 1'b0,
        FIELD_EZ = 1'b1
    } field_sel_t;

    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_RD_HY   = 3'd1,
        S_RD_EZ   = 3'd2,
        S_WAIT_WR = 3'd3,
        S_WR      = 3'd4,
        S_FINISH  = 3'd5
    } seq_state_t;

    // a full buffer, or whatever is left at the tail of the pass
    function automatic chunk_count_t chunk_len_f(input word_count_t remaining);
        chunk_count_t len;
        if (remaining > BUF_WORDS)
            len = chunk_count_t'(BUF_WORDS);
        else
            len = chunk_count_t'(remaining);
        return len;
    endfunction

endpackage

`default_nettype wire

// ==== fdtd_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_mem_ctrl
    import fdtd_cfg_pkg::*, fdtd_mem_pkg::*;
(
    input  wire               ACLK,
    input  wire               ARESETn,

    // run control
    input  wire               start_i,
    input  wire word_addr_t   hy_base_i,
    input  wire word_addr_t   ez_base_i,
    input  wire word_count_t  size_i,
    input  wire               int_en_i,
    input  wire               clr_int_i,

    // line buffer fill
    output logic              hy_rd_valid_o,
    output logic              ez_rd_valid_o,
    output field_word_t       rd_data_o,
    output logic              chunk_ready_o,

    // write-back
    input  wire               wr_start_i,
    input  wire field_sel_t   wr_field_i,
    output logic              fetch_o,
    input  wire field_word_t  new_data_i,
    output chunk_count_t      chunk_len_o,

    // status
    output logic              busy_o,
    output logic              int_pending_o,
    output logic              irq_o,
    output logic              hy_done_o,
    output logic              ez_done_o,

    // word memory
    output mem_rd_req_t       mem_rd_o,
    input  wire mem_rd_rsp_t  mem_rsp_i,
    output mem_wr_req_t       mem_wr_o
);

    seq_ctrl_t   seq_ctrl;
    word_addr_t  rd_addr;
    word_addr_t  wr_addr;
    word_count_t remaining;
    logic        rd_return;
    logic        finish;
    field_sel_t  finish_field;

    fdtd_seq_fsm seq_fsm_inst (
        .ACLK           ( ACLK          ),
        .ARESETn        ( ARESETn       ),
        .start_i        ( start_i       ),
        .wr_start_i     ( wr_start_i    ),
        .wr_field_i     ( wr_field_i    ),
        .remaining_i    ( remaining     ),
        .rd_return_i    ( rd_return     ),
        .ctrl_o         ( seq_ctrl      ),
        .chunk_ready_o  ( chunk_ready_o ),
        .chunk_len_o    ( chunk_len_o   ),
        .fetch_o        ( fetch_o       ),
        .busy_o         ( busy_o        ),
        .finish_o       ( finish        ),
        .finish_field_o ( finish_field  )
    );

    fdtd_addr_gen addr_gen_inst (
        .ACLK        ( ACLK      ),
        .ARESETn     ( ARESETn   ),
        .ctrl_i      ( seq_ctrl  ),
        .hy_base_i   ( hy_base_i ),
        .ez_base_i   ( ez_base_i ),
        .size_i      ( size_i    ),
        .rd_addr_o   ( rd_addr   ),
        .wr_addr_o   ( wr_addr   ),
        .remaining_o ( remaining )
    );

    fdtd_mem_port mem_port_inst (
        .ACLK          ( ACLK          ),
        .ARESETn       ( ARESETn       ),
        .ctrl_i        ( seq_ctrl      ),
        .rd_addr_i     ( rd_addr       ),
        .wr_addr_i     ( wr_addr       ),
        .new_data_i    ( new_data_i    ),
        .mem_rd_o      ( mem_rd_o      ),
        .mem_rsp_i     ( mem_rsp_i     ),
        .mem_wr_o      ( mem_wr_o      ),
        .rd_return_o   ( rd_return     ),
        .hy_rd_valid_o ( hy_rd_valid_o ),
        .ez_rd_valid_o ( ez_rd_valid_o ),
        .rd_data_o     ( rd_data_o     )
    );

    fdtd_status status_inst (
        .ACLK           ( ACLK          ),
        .ARESETn        ( ARESETn       ),
        .start_i        ( start_i       ),
        .busy_i         ( busy_o        ),
        .finish_i       ( finish        ),
        .finish_field_i ( finish_field  ),
        .int_en_i       ( int_en_i      ),
        .clr_int_i      ( clr_int_i     ),
        .int_pending_o  ( int_pending_o ),
        .irq_o          ( irq_o         ),
        .hy_done_o      ( hy_done_o     ),
        .ez_done_o      ( ez_done_o     )
    );

endmodule

`default_nettype wire

// ==== fdtd_mem_pkg.sv ====
`default_nettype none

package fdtd_mem_pkg;

    import fdtd_cfg_pkg::*;

    // outstanding read tags, more than the deepest read latency
    localparam int RD_TAG_DEPTH = 16;
    typedef logic [$clog2(RD_TAG_DEPTH)-1:0] rd_tag_ptr_t;

    typedef struct packed {
        logic       strobe;
        word_addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic        valid;
        field_word_t data;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic        strobe;
        word_addr_t  addr;
        field_word_t data;
    } mem_wr_req_t;

    // per-cycle commands from the sequencer
    typedef struct packed {
        logic       load;
        logic       rd_issue;
        field_sel_t rd_field;
        logic       wr_issue;
        field_sel_t wr_field;
        logic       chunk_adv;
    } seq_ctrl_t;

endpackage

`default_nettype wire

// ==== fdtd_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_mem_port
    import fdtd_cfg_pkg::*, fdtd_mem_pkg::*;
(
    input  wire               ACLK,
    input  wire               ARESETn,

    input  wire seq_ctrl_t    ctrl_i,
    input  wire word_addr_t   rd_addr_i,
    input  wire word_addr_t   wr_addr_i,
    input  wire field_word_t  new_data_i,

    output mem_rd_req_t       mem_rd_o,
    input  wire mem_rd_rsp_t  mem_rsp_i,
    output mem_wr_req_t       mem_wr_o,

    output logic              rd_return_o,
    output logic              hy_rd_valid_o,
    output logic              ez_rd_valid_o,
    output field_word_t       rd_data_o
);

    rd_tag_ptr_t tag_wr_ptr_q;
    rd_tag_ptr_t tag_rd_ptr_q;
    field_sel_t  tag_mem [RD_TAG_DEPTH];
    field_sel_t  head_tag;

    logic        wr_strobe_q;
    word_addr_t  wr_addr_q;
    field_word_t wr_data_q;

    ////////////////////
    // read side
    ////////////////////
    always_comb
    begin
        mem_rd_o.strobe = ctrl_i.rd_issue;
        mem_rd_o.addr   = rd_addr_i;
    end

    // field tag per issued read, popped in order by the returns
    always_ff @(posedge ACLK)
    begin
        if (ctrl_i.rd_issue)
            tag_mem[tag_wr_ptr_q] <= ctrl_i.rd_field;
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            tag_wr_ptr_q <= '0;
            tag_rd_ptr_q <= '0;
        end
        else
        begin
            if (ctrl_i.rd_issue)
                tag_wr_ptr_q <= tag_wr_ptr_q + 1'b1;
            if (mem_rsp_i.valid)
                tag_rd_ptr_q <= tag_rd_ptr_q + 1'b1;
        end
    end

    assign head_tag      = tag_mem[tag_rd_ptr_q];
    assign rd_return_o   = mem_rsp_i.valid;
    assign hy_rd_valid_o = mem_rsp_i.valid && (head_tag == FIELD_HY);
    assign ez_rd_valid_o = mem_rsp_i.valid && (head_tag == FIELD_EZ);
    assign rd_data_o     = mem_rsp_i.data;

    ////////////////////
    // write side
    ////////////////////
    // new_data_i is sampled at the edge that closes the fetch cycle
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            wr_strobe_q <= 1'b0;
        else
            wr_strobe_q <= ctrl_i.wr_issue;
    end

    always_ff @(posedge ACLK)
    begin
        if (ctrl_i.wr_issue)
        begin
            wr_addr_q <= wr_addr_i;
            wr_data_q <= new_data_i;
        end
    end

    always_comb
    begin
        mem_wr_o.strobe = wr_strobe_q;
        mem_wr_o.addr   = wr_addr_q;
        mem_wr_o.data   = wr_data_q;
    end

endmodule

`default_nettype wire

// ==== fdtd_seq_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_seq_fsm
    import fdtd_cfg_pkg::*, fdtd_mem_pkg::*;
(
    input  wire               ACLK,
    input  wire               ARESETn,

    input  wire               start_i,
    input  wire               wr_start_i,
    input  wire field_sel_t   wr_field_i,
    input  wire word_count_t  remaining_i,
    input  wire               rd_return_i,

    output seq_ctrl_t         ctrl_o,
    output logic              chunk_ready_o,
    output chunk_count_t      chunk_len_o,
    output logic              fetch_o,
    output logic              busy_o,
    output logic              finish_o,
    output field_sel_t        finish_field_o
);

    seq_state_t   state_q;
    seq_state_t   state_d;

    chunk_count_t len;
    chunk_count_t issue_cnt_q;
    chunk_count_t hy_ret_cnt_q;
    chunk_count_t ez_ret_cnt_q;
    chunk_count_t wr_cnt_q;
    field_sel_t   wr_field_q;
    logic         chunk_ready_q;
    logic         ez_ret_last;

    // remaining count only moves on chunk_adv, so it holds for the whole chunk
    assign len = chunk_len_f(remaining_i);

    // returns are in order, hy words first
    assign ez_ret_last = rd_return_i && (hy_ret_cnt_q == len)
                         && (ez_ret_cnt_q == len - 1'b1);

    ////////////////////
    // next state
    ////////////////////
    always_comb
    begin
        state_d         = state_q;
        ctrl_o          = '0;
        ctrl_o.rd_field = FIELD_HY;
        ctrl_o.wr_field = wr_field_q;

        case (state_q)
            S_IDLE:
            begin
                if (start_i)
                begin
                    ctrl_o.load = 1'b1;
                    state_d     = S_RD_HY;
                end
            end

            // hy issue only; its returns are counted through both read states
            S_RD_HY:
            begin
                ctrl_o.rd_issue = 1'b1;
                if (issue_cnt_q == len - 1'b1)
                    state_d = S_RD_EZ;
            end

            S_RD_EZ:
            begin
                ctrl_o.rd_field = FIELD_EZ;
                ctrl_o.rd_issue = (issue_cnt_q < len);
                if (ez_ret_last)
                    state_d = S_WAIT_WR;
            end

            S_WAIT_WR:
            begin
                if (wr_start_i)
                    state_d = S_WR;
            end

            S_WR:
            begin
                if (wr_cnt_q < len)
                    ctrl_o.wr_issue = 1'b1;
                else
                begin
                    // last write is on the bus this cycle
                    ctrl_o.chunk_adv = 1'b1;
                    if (remaining_i > BUF_WORDS)
                        state_d = S_RD_HY;
                    else
                        state_d = S_FINISH;
                end
            end

            S_FINISH:
                state_d = S_IDLE;

            default:
                state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            state_q <= S_IDLE;
        else
            state_q <= state_d;
    end

    ////////////////////
    // chunk counters
    ////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            issue_cnt_q  <= '0;
            hy_ret_cnt_q <= '0;
            ez_ret_cnt_q <= '0;
        end
        else if (state_q == S_RD_HY || state_q == S_RD_EZ)
        begin
            if (state_d == S_RD_EZ && state_q == S_RD_HY)
                issue_cnt_q <= '0;
            else if (ctrl_o.rd_issue)
                issue_cnt_q <= issue_cnt_q + 1'b1;

            if (rd_return_i)
            begin
                if (hy_ret_cnt_q != len)
                    hy_ret_cnt_q <= hy_ret_cnt_q + 1'b1;
                else
                    ez_ret_cnt_q <= ez_ret_cnt_q + 1'b1;
            end
        end
        else
        begin
            issue_cnt_q  <= '0;
            hy_ret_cnt_q <= '0;
            ez_ret_cnt_q <= '0;
        end
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            wr_cnt_q <= '0;
        else if (state_q != S_WR)
            wr_cnt_q <= '0;
        else if (ctrl_o.wr_issue)
            wr_cnt_q <= wr_cnt_q + 1'b1;
    end

    // field chosen by the compute side, held until the pass or chunk ends
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            wr_field_q <= FIELD_HY;
        else if (state_q == S_WAIT_WR && wr_start_i)
            wr_field_q <= wr_field_i;
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            chunk_ready_q <= 1'b0;
        else
            chunk_ready_q <= (state_q == S_RD_EZ) && ez_ret_last;
    end

    assign chunk_ready_o  = chunk_ready_q;
    assign chunk_len_o    = len;
    assign fetch_o        = ctrl_o.wr_issue;
    assign busy_o         = (state_q != S_IDLE);
    assign finish_o       = (state_q == S_FINISH);
    assign finish_field_o = wr_field_q;

endmodule

`default_nettype wire

// ==== fdtd_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_status
    import fdtd_cfg_pkg::*;
(
    input  wire              ACLK,
    input  wire              ARESETn,

    input  wire              start_i,
    input  wire              busy_i,
    input  wire              finish_i,
    input  wire field_sel_t  finish_field_i,
    input  wire              int_en_i,
    input  wire              clr_int_i,

    output logic             int_pending_o,
    output logic             irq_o,
    output logic             hy_done_o,
    output logic             ez_done_o
);

    logic busy_q;
    logic run_start;

    // a start while busy is dropped by the sequencer as well
    assign run_start = start_i && !busy_i;

    ////////////////////
    // interrupt
    ////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            busy_q        <= 1'b0;
            int_pending_o <= 1'b0;
        end
        else
        begin
            busy_q <= busy_i;
            // clear beats a set in the same cycle
            if (clr_int_i)
                int_pending_o <= 1'b0;
            else if (busy_q && !busy_i)
                int_pending_o <= 1'b1;
        end
    end

    assign irq_o = int_en_i && int_pending_o;

    // done flags
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            hy_done_o <= 1'b0;
            ez_done_o <= 1'b0;
        end
        else if (run_start)
        begin
            hy_done_o <= 1'b0;
            ez_done_o <= 1'b0;
        end
        else if (finish_i)
        begin
            if (finish_field_i == FIELD_HY)
                hy_done_o <= 1'b1;
            else
                ez_done_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
fdtd_cfg_pkg.sv
fdtd_mem_pkg.sv
fdtd_addr_gen.sv
fdtd_mem_port.sv
fdtd_seq_fsm.sv
fdtd_status.sv
fdtd_mem_ctrl.sv
tb_word_mem.sv
tb_fdtd_mem_ctrl.sv

// ==== tb_fdtd_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fdtd_mem_ctrl
    import fdtd_cfg_pkg::*, fdtd_mem_pkg::*;
();

    typedef struct packed {
        field_sel_t  field;
        word_count_t size;
        word_addr_t  hy_base;
        word_addr_t  ez_base;
        logic        int_en;
        logic [3:0]  lat_max;
    } run_case_t;

    localparam field_word_t WB_MASK   = 32'hA5A5_0F0F;
    localparam int          MEM_WORDS = 65536;
    localparam int          MAX_CASES = 64;

    logic         ACLK = 1'b0;
    logic         ARESETn = 1'b0;
    logic         start;
    word_addr_t   hy_base;
    word_addr_t   ez_base;
    word_count_t  size;
    logic         int_en;
    logic         clr_int;
    logic         hy_rd_valid;
    logic         ez_rd_valid;
    field_word_t  rd_data;
    logic         chunk_ready;
    logic         wr_start;
    field_sel_t   wr_field;
    logic         fetch;
    field_word_t  new_data;
    chunk_count_t chunk_len;
    logic         busy;
    logic         int_pending;
    logic         irq;
    logic         hy_done;
    logic         ez_done;
    mem_rd_req_t  mem_rd;
    mem_rd_rsp_t  mem_rsp;
    mem_wr_req_t  mem_wr;
    logic [3:0]   lat_max;

    logic [31:0]  case_words [6 * MAX_CASES];
    run_case_t    cases[$];
    field_word_t  ref_mem [MEM_WORDS];
    field_word_t  hy_q[$];
    field_word_t  ez_q[$];
    field_word_t  wb_q[$];
    int           cycle_count = 0;
    int           cycle_limit = 1000;
    int           error_count = 0;
    int           pass_count = 0;
    int           fail_count = 0;
    int           seed_val;

    fdtd_mem_ctrl fdtd_mem_ctrl_inst (
        .ACLK          ( ACLK        ),
        .ARESETn       ( ARESETn     ),
        .start_i       ( start       ),
        .hy_base_i     ( hy_base     ),
        .ez_base_i     ( ez_base     ),
        .size_i        ( size        ),
        .int_en_i      ( int_en      ),
        .clr_int_i     ( clr_int     ),
        .hy_rd_valid_o ( hy_rd_valid ),
        .ez_rd_valid_o ( ez_rd_valid ),
        .rd_data_o     ( rd_data     ),
        .chunk_ready_o ( chunk_ready ),
        .wr_start_i    ( wr_start    ),
        .wr_field_i    ( wr_field    ),
        .fetch_o       ( fetch       ),
        .new_data_i    ( new_data    ),
        .chunk_len_o   ( chunk_len   ),
        .busy_o        ( busy        ),
        .int_pending_o ( int_pending ),
        .irq_o         ( irq         ),
        .hy_done_o     ( hy_done     ),
        .ez_done_o     ( ez_done     ),
        .mem_rd_o      ( mem_rd      ),
        .mem_rsp_i     ( mem_rsp     ),
        .mem_wr_o      ( mem_wr      )
    );

    tb_word_mem word_mem_inst (
        .ACLK      ( ACLK    ),
        .ARESETn   ( ARESETn ),
        .lat_max_i ( lat_max ),
        .mem_rd_i  ( mem_rd  ),
        .mem_rsp_o ( mem_rsp ),
        .mem_wr_i  ( mem_wr  )
    );

    always #10 ACLK = ~ACLK;

    // run limit
    always @(posedge ACLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        error_count++;
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        error_count++;
    endtask

    task automatic load_cases;
        run_case_t c;
        int        n;
        int        limit;
        for (n = 0; n < 6 * MAX_CASES; n++)
            case_words[n] = '0;
        $readmemh("fdtd_cases.txt", case_words);
        limit = 200;
        n = 0;
        // a zero size ends the list
        while (n < MAX_CASES && case_words[6 * n + 1] != 0)
        begin
            c.field   = field_sel_t'(case_words[6 * n][0]);
            c.size    = word_count_t'(case_words[6 * n + 1]);
            c.hy_base = word_addr_t'(case_words[6 * n + 2]);
            c.ez_base = word_addr_t'(case_words[6 * n + 3]);
            c.int_en  = case_words[6 * n + 4][0];
            c.lat_max = case_words[6 * n + 5][3:0];
            cases.push_back(c);
            limit += int'(c.size) * (2 * int'(c.lat_max) + 4);
            n++;
        end
        cycle_limit = limit;
        if (cases.size() == 0)
            note_failure("no test cases found in fdtd_cases.txt");
    endtask

    task automatic fill_memory;
        int          a;
        field_word_t w;
        for (a = 0; a < MEM_WORDS; a++)
        begin
            // random word folded with its address
            w = $urandom ^ {a[15:0], ~a[15:0]};
            word_mem_inst.mem[a] = w;
            ref_mem[a] = w;
        end
    endtask

    task automatic check_reset_state;
        int errs_before;
        errs_before = error_count;
        if (busy !== 1'b0)
            show_mismatch("busy_o", busy, 0);
        if (irq !== 1'b0)
            show_mismatch("irq_o", irq, 0);
        if (int_pending !== 1'b0)
            show_mismatch("int_pending_o", int_pending, 0);
        if (hy_done !== 1'b0)
            show_mismatch("hy_done_o", hy_done, 0);
        if (ez_done !== 1'b0)
            show_mismatch("ez_done_o", ez_done, 0);
        if (hy_rd_valid !== 1'b0)
            show_mismatch("hy_rd_valid_o", hy_rd_valid, 0);
        if (ez_rd_valid !== 1'b0)
            show_mismatch("ez_rd_valid_o", ez_rd_valid, 0);
        if (chunk_ready !== 1'b0)
            show_mismatch("chunk_ready_o", chunk_ready, 0);
        if (fetch !== 1'b0)
            show_mismatch("fetch_o", fetch, 0);
        if (mem_rd.strobe !== 1'b0)
            show_mismatch("mem_rd_o.strobe", mem_rd.strobe, 0);
        if (mem_wr.strobe !== 1'b0)
            show_mismatch("mem_wr_o.strobe", mem_wr.strobe, 0);
        if (error_count == errs_before)
        begin
            pass_count++;
            $display("reset state ok");
        end
        else
        begin
            fail_count++;
            $display("reset state FAILED");
        end
    endtask

    ////////////////////
    // one run
    ////////////////////
    task automatic run_case(input run_case_t c, input int idx);
        int          errs_before;
        int          left;
        int          exp_len;
        int          chunks;
        int          hy_off;
        int          ez_off;
        int          wr_wait;
        int          n;
        logic        fetch_prev;
        word_addr_t  addr;
        word_addr_t  base;
        errs_before = error_count;
        left        = int'(c.size);
        exp_len     = (left > int'(BUF_WORDS)) ? int'(BUF_WORDS) : left;
        chunks      = 0;
        hy_off      = 0;
        ez_off      = 0;
        wr_wait     = -1;
        fetch_prev  = 1'b0;
        hy_q.delete();
        ez_q.delete();
        wb_q.delete();

        hy_base = c.hy_base;
        ez_base = c.ez_base;
        size    = c.size;
        int_en  = c.int_en;
        lat_max = c.lat_max;
        start   = 1'b1;
        @(negedge ACLK);
        start = 1'b0;
        if (busy !== 1'b1)
            show_mismatch("busy_o", busy, 1);
        if (hy_done !== 1'b0)
            show_mismatch("hy_done_o", hy_done, 0);
        if (ez_done !== 1'b0)
            show_mismatch("ez_done_o", ez_done, 0);

        // line buffer model, one pass per cycle until busy drops
        while (busy === 1'b1)
        begin
            wr_start = 1'b0;
            new_data = '0;
            if (mem_wr.strobe !== fetch_prev)
                note_failure("write strobe not exactly one cycle after its fetch");
            if (hy_rd_valid === 1'b1 && ez_rd_valid === 1'b1)
                note_failure("hy and ez read valids high in the same cycle");
            if (hy_rd_valid === 1'b1)
            begin
                if (ez_q.size() != 0 || hy_q.size() >= exp_len)
                    note_failure("hy word returned out of order");
                addr = c.hy_base + word_addr_t'(hy_off);
                if (rd_data !== ref_mem[addr])
                    show_mismatch("rd_data_o", rd_data, ref_mem[addr]);
                hy_q.push_back(rd_data);
                hy_off++;
            end
            if (ez_rd_valid === 1'b1)
            begin
                if (hy_q.size() != exp_len || ez_q.size() >= exp_len)
                    note_failure("ez word returned out of order");
                addr = c.ez_base + word_addr_t'(ez_off);
                if (rd_data !== ref_mem[addr])
                    show_mismatch("rd_data_o", rd_data, ref_mem[addr]);
                ez_q.push_back(rd_data);
                ez_off++;
            end
            if (chunk_ready === 1'b1)
            begin
                if (chunk_len !== chunk_count_t'(exp_len))
                    show_mismatch("chunk_len_o", chunk_len, exp_len);
                if (hy_q.size() != exp_len || ez_q.size() != exp_len)
                    note_failure("chunk ready before all reads of the chunk returned");
                if (c.field == FIELD_HY)
                    wb_q = hy_q;
                else
                    wb_q = ez_q;
                hy_q.delete();
                ez_q.delete();
                chunks++;
                left    = left - exp_len;
                exp_len = (left > int'(BUF_WORDS)) ? int'(BUF_WORDS) : left;
                wr_wait = $urandom % 6;
            end
            if (wr_wait == 0)
            begin
                wr_start = 1'b1;
                wr_field = c.field;
            end
            if (wr_wait >= 0)
                wr_wait--;
            // new word goes out in the fetch cycle itself
            if (fetch === 1'b1)
            begin
                if (wb_q.size() == 0)
                    note_failure("fetch with no word left in the line buffer");
                else
                    new_data = wb_q.pop_front() ^ WB_MASK;
            end
            fetch_prev = fetch;
            @(negedge ACLK);
        end

        n = (int'(c.size) + int'(BUF_WORDS) - 1) / int'(BUF_WORDS);
        if (chunks != n)
            note_failure($sformatf("saw %0d chunk ready pulses instead of %0d", chunks, n));
        if (wb_q.size() != 0)
            note_failure("not every buffered word was fetched back");
        if (mem_wr.strobe !== fetch_prev)
            note_failure("write strobe not exactly one cycle after its fetch");

        // status around the falling edge of busy
        if (hy_done !== (c.field == FIELD_HY))
            show_mismatch("hy_done_o", hy_done, c.field == FIELD_HY);
        if (ez_done !== (c.field == FIELD_EZ))
            show_mismatch("ez_done_o", ez_done, c.field == FIELD_EZ);
        if (int_pending !== 1'b0)
            show_mismatch("int_pending_o", int_pending, 0);
        @(negedge ACLK);
        if (int_pending !== 1'b1)
            show_mismatch("int_pending_o", int_pending, 1);
        if (irq !== c.int_en)
            show_mismatch("irq_o", irq, c.int_en);
        clr_int = 1'b1;
        @(negedge ACLK);
        clr_int = 1'b0;
        if (int_pending !== 1'b0)
            show_mismatch("int_pending_o", int_pending, 0);
        if (irq !== 1'b0)
            show_mismatch("irq_o", irq, 0);

        // written region toggles by the mask, everything else holds
        base = (c.field == FIELD_HY) ? c.hy_base : c.ez_base;
        for (n = 0; n < int'(c.size); n++)
        begin
            addr = base + word_addr_t'(n);
            ref_mem[addr] = ref_mem[addr] ^ WB_MASK;
        end
        for (n = 0; n < MEM_WORDS; n++)
        begin
            if (word_mem_inst.mem[n] !== ref_mem[n])
                show_mismatch($sformatf("mem[%h]", n[15:0]), word_mem_inst.mem[n], ref_mem[n]);
        end

        if (error_count == errs_before)
        begin
            pass_count++;
            $display("case %0d %s size %0d ok", idx, (c.field == FIELD_HY) ? "hy" : "ez",
                     c.size);
        end
        else
        begin
            fail_count++;
            $display("case %0d %s size %0d FAILED with %0d errors", idx,
                     (c.field == FIELD_HY) ? "hy" : "ez", c.size, error_count - errs_before);
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial
    begin
        start    = 1'b0;
        hy_base  = '0;
        ez_base  = '0;
        size     = '0;
        int_en   = 1'b0;
        clr_int  = 1'b0;
        wr_start = 1'b0;
        wr_field = FIELD_HY;
        new_data = '0;
        lat_max  = 4'd1;
        seed_val = $urandom(32'h5d1b);

        load_cases();
        fill_memory();
        repeat (16) @(negedge ACLK);
        ARESETn = 1'b1;
        @(negedge ACLK);
        check_reset_state();

        foreach (cases[i])
            run_case(cases[i], i);

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_word_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_word_mem
    import fdtd_cfg_pkg::*, fdtd_mem_pkg::*;
(
    input  wire               ACLK,
    input  wire               ARESETn,

    input  wire [3:0]         lat_max_i,
    input  wire mem_rd_req_t  mem_rd_i,
    output mem_rd_rsp_t       mem_rsp_o,
    input  wire mem_wr_req_t  mem_wr_i
);

    field_word_t mem [65536];

    // reads in flight in issue order and the cycle each one falls due
    field_word_t rsp_data_q[$];
    int          rsp_due_q[$];
    int          cycle;
    int          due;

    initial
    begin
        mem_rsp_o = '0;
    end

    always @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            cycle = 0;
            rsp_data_q.delete();
            rsp_due_q.delete();
            mem_rsp_o <= '0;
        end
        else
        begin
            cycle = cycle + 1;
            if (mem_rd_i.strobe)
            begin
                // latency of 1 to lat_max cycles and never ahead of an older read
                due = cycle + int'($urandom % lat_max_i);
                if (rsp_due_q.size() != 0 && due <= rsp_due_q[$])
                    due = rsp_due_q[$] + 1;
                rsp_due_q.push_back(due);
                rsp_data_q.push_back(mem[mem_rd_i.addr]);
            end

            if (rsp_due_q.size() != 0 && rsp_due_q[0] == cycle)
            begin
                due = rsp_due_q.pop_front();
                mem_rsp_o.valid <= 1'b1;
                mem_rsp_o.data  <= rsp_data_q.pop_front();
            end
            else
                mem_rsp_o <= '0;

            if (mem_wr_i.strobe)
                mem[mem_wr_i.addr] <= mem_wr_i.data;
        end
    end

endmodule

`default_nettype wire
